//--- include/micro_program.svh
// Fixed microcode table, one case item per ROM word.
// Selectors are packed {d, c, b, a}, literal registers the same way.
// Unlisted addresses return a terminating no-op.
`ifndef MICRO_PROGRAM_SVH
`define MICRO_PROGRAM_SVH

// Builds a micro-word from its fields.
function automatic micro_pkg::micro_word_t micro_pack(
  input logic        end_seq,
  input logic [2:0]  imm_sel,
  input logic        var_off,
  input logic [7:0]  var_dcba,
  input logic        var_s,
  input logic [17:0] high_ir,
  input logic [15:0] reg_dcba,
  input logic [1:0]  micro_s
);
  micro_pkg::micro_word_t w;
  w.end_seq = end_seq;
  w.var_imm = micro_pkg::imm_sel_e'(imm_sel);
  w.var_off = var_off;
  w.var_d   = var_dcba[7:6];
  w.var_c   = var_dcba[5:4];
  w.var_b   = var_dcba[3:2];
  w.var_a   = var_dcba[1:0];
  w.var_s   = var_s;
  w.high_ir = high_ir;
  w.micro_d = reg_dcba[15:12];
  w.micro_c = reg_dcba[11:8];
  w.micro_b = reg_dcba[7:4];
  w.micro_a = reg_dcba[3:0];
  w.micro_s = micro_s;
  return w;
endfunction

// Micro-word at an address. Sequences start at 0, 1, 4 and 8.
function automatic micro_pkg::micro_word_t micro_program(input micro_pkg::micro_addr_t addr);
  micro_pkg::micro_word_t w;
  case (addr)
    // Register move, one word.
    7'd0: w = micro_pack(1'b1, 3'd4, 1'b0, 8'b10_01_00_11, 1'b0, 18'h01a03, 16'h7531, 2'd1);
    // Memory operand, three words.
    7'd1: w = micro_pack(1'b0, 3'd3, 1'b1, 8'b00_00_01_01, 1'b1, 18'h02b10, 16'h1234, 2'd2);
    7'd2: w = micro_pack(1'b0, 3'd0, 1'b0, 8'b01_10_10_10, 1'b0, 18'h03c21, 16'h5678, 2'd3);
    7'd3: w = micro_pack(1'b1, 3'd1, 1'b1, 8'b11_11_11_00, 1'b1, 18'h24d32, 16'h9abc, 2'd0);
    // Selector sweep, four words.
    7'd4: w = micro_pack(1'b0, 3'd2, 1'b0, 8'b00_00_00_00, 1'b0, 18'h05e43, 16'hdef1, 2'd2);
    7'd5: w = micro_pack(1'b0, 3'd5, 1'b1, 8'b01_01_01_01, 1'b1, 18'h16f54, 16'h2468, 2'd1);
    7'd6: w = micro_pack(1'b0, 3'd6, 1'b0, 8'b10_10_10_10, 1'b0, 18'h37065, 16'h3579, 2'd3);
    7'd7: w = micro_pack(1'b1, 3'd7, 1'b0, 8'b11_11_11_11, 1'b1, 18'h08176, 16'h8ace, 2'd0);
    // Immediate to memory, two words.
    7'd8: w = micro_pack(1'b0, 3'd4, 1'b1, 8'b01_00_10_01, 1'b1, 18'h29287, 16'hfedc, 2'd1);
    7'd9: w = micro_pack(1'b1, 3'd0, 1'b0, 8'b00_11_00_11, 1'b0, 18'h3a398, 16'h0f0f, 2'd2);
    default: begin
      w = '0;                                       // No-op.
      w.end_seq = 1'b1;                             // Ends a wild sequence.
    end
  endcase
  return w;
endfunction

`endif

//--- logic/micro_pkg.sv
// Shared widths and types for the microcode issue stage.
// Field widths are fixed by the architecture. Only the ROM depth is a parameter.
// The micro-word bit layout below is the ROM table format. Keep the two in step.

package micro_pkg;

  localparam int MICRO_ADDR_W = 7;                  // Micro-address width.

  typedef logic [MICRO_ADDR_W-1:0] micro_addr_t;    // Microcode ROM address.
  typedef logic [3:0]              reg_sel_t;       // Register file address.
  typedef logic [1:0]              seg_sel_t;       // Segment register number.
  typedef logic [15:0]             word_t;          // Data word, disp or imm.
  typedef logic [17:0]             high_ir_t;       // Opcode and control bits.

  // Immediate source for the issued word.
  typedef enum logic [2:0] {
    IMM_ZERO  = 3'd0,                               // Constant 0.
    IMM_TWO   = 3'd1,                               // Constant 2.
    IMM_FOUR  = 3'd2,                               // Constant 4.
    IMM_DISP  = 3'd3,                               // Instruction displacement.
    IMM_IMM   = 3'd4,                               // Instruction immediate.
    IMM_ONES  = 3'd5,                               // Constant FFFF.
    IMM_THREE = 3'd6,                               // Constant 3.
    IMM_ONE   = 3'd7                                // Constant 1.
  } imm_sel_e;

  // One ROM word, 50 bits, msb first.
  typedef struct packed {
    logic       end_seq;                            // Last word of a sequence.
    imm_sel_e   var_imm;                            // Immediate source.
    logic       var_off;                            // Pass displacement out.
    logic [1:0] var_d;                              // Field d source.
    logic [1:0] var_c;                              // Field c source.
    logic [1:0] var_b;                              // Field b source.
    logic [1:0] var_a;                              // Field a source.
    logic       var_s;                              // Take instruction segment.
    high_ir_t   high_ir;
    reg_sel_t   micro_d;                            // Literal register fields.
    reg_sel_t   micro_c;
    reg_sel_t   micro_b;
    reg_sel_t   micro_a;
    seg_sel_t   micro_s;                            // Literal segment.
  } micro_word_t;

  // Decoded instruction as handed over by the decoder.
  typedef struct packed {
    micro_addr_t start;                             // First micro-address.
    reg_sel_t    src;
    reg_sel_t    dst;
    reg_sel_t    base;
    reg_sel_t    index;
    seg_sel_t    seg;
    word_t       off;                               // Displacement.
    word_t       imm;                               // Immediate.
  } inst_t;

  // Internal instruction register, 36 bits.
  typedef struct packed {
    high_ir_t high_ir;
    reg_sel_t addr_d;
    reg_sel_t addr_c;
    reg_sel_t addr_b;
    reg_sel_t addr_a;
    seg_sel_t addr_s;
  } ir_t;

  // One issued step, 69 bits.
  typedef struct packed {
    ir_t   ir;
    word_t off;
    word_t imm;
    logic  end_seq;
  } issue_t;

  typedef enum logic {
    IDLE = 1'b0,                                    // Waiting for an instruction.
    RUN  = 1'b1                                     // Issuing a sequence.
  } seq_state_e;

endpackage

//--- logic/micro_rom.sv
// Combinational microcode store, zero cycles of latency.
// Addresses at or above ROM_DEPTH give a terminating no-op and an error.

`timescale 1ns/1ns

module micro_rom #(
  parameter int ROM_DEPTH = 16                      // Words in the table.
) (
  input  micro_pkg::micro_addr_t addr_i,
  output micro_pkg::micro_word_t word_o
);

  `include "micro_program.svh"

  logic in_range;                                   // Address within table.

  assign in_range = (32'(addr_i) < ROM_DEPTH);

  always_comb begin
    if (in_range) begin
      word_o = micro_program(addr_i);               // Table lookup.
    end else begin
      word_o = '0;
      word_o.end_seq = 1'b1;                        // Force the sequence to end.
    end
  end

  // Catches a wild start address or a runaway sequence.
  always_comb begin
    if (!$isunknown(addr_i)) begin
      assert (in_range)
        else $error("micro_rom: address %0d beyond depth %0d", addr_i, ROM_DEPTH);
    end
  end

endmodule

//--- logic/micro_data.sv
// Operand substitution for one micro-word.
// Purely combinational. The instruction must be held stable by the sequencer.
// Field b, c and d have no base selector, so their code 3 repeats src.

`timescale 1ns/1ns

module micro_data (
  input  micro_pkg::micro_word_t word_i,
  input  micro_pkg::inst_t       inst_i,
  output micro_pkg::issue_t      issue_o
);

  micro_pkg::ir_t   ir;                             // Substituted register fields.
  micro_pkg::word_t off_w;                          // Gated displacement.
  micro_pkg::word_t imm_w;                          // Selected immediate.

  // Register address fields.
  always_comb begin
    ir.high_ir = word_i.high_ir;                    // Opcode bits pass through.

    case (word_i.var_a)
      2'd0:    ir.addr_a = word_i.micro_a;          // Literal.
      2'd1:    ir.addr_a = inst_i.base;
      2'd2:    ir.addr_a = inst_i.dst;
      default: ir.addr_a = inst_i.src;
    endcase

    case (word_i.var_b)
      2'd0:    ir.addr_b = word_i.micro_b;
      2'd1:    ir.addr_b = inst_i.index;
      default: ir.addr_b = inst_i.src;              // Codes 2 and 3.
    endcase

    case (word_i.var_c)
      2'd0:    ir.addr_c = word_i.micro_c;
      2'd1:    ir.addr_c = inst_i.dst;
      default: ir.addr_c = inst_i.src;
    endcase

    case (word_i.var_d)
      2'd0:    ir.addr_d = word_i.micro_d;
      2'd1:    ir.addr_d = inst_i.dst;
      default: ir.addr_d = inst_i.src;
    endcase

    ir.addr_s = word_i.var_s ? inst_i.seg : word_i.micro_s; // Segment override.
  end

  // Displacement only when the word asks for it.
  assign off_w = word_i.var_off ? inst_i.off : '0;

  // Immediate source.
  always_comb begin
    case (word_i.var_imm)
      micro_pkg::IMM_ZERO:  imm_w = 16'h0000;
      micro_pkg::IMM_TWO:   imm_w = 16'h0002;       // Word step.
      micro_pkg::IMM_FOUR:  imm_w = 16'h0004;       // Far pointer step.
      micro_pkg::IMM_DISP:  imm_w = inst_i.off;
      micro_pkg::IMM_IMM:   imm_w = inst_i.imm;
      micro_pkg::IMM_ONES:  imm_w = 16'hffff;       // Minus one.
      micro_pkg::IMM_THREE: imm_w = 16'h0003;
      micro_pkg::IMM_ONE:   imm_w = 16'h0001;
      default:              imm_w = 16'h0000;
    endcase
  end

  always_comb begin
    issue_o.ir      = ir;
    issue_o.off     = off_w;
    issue_o.imm     = imm_w;
    issue_o.end_seq = word_i.end_seq;               // Pass through.
  end

endmodule

//--- logic/micro_seq.sv
// Sequencer for the issue stage, two states.
// First word is valid the cycle after acceptance. A new instruction is taken
// on the edge where the end_seq word leaves, so sequences run back to back.
// The held instruction has no reset and is only meaningful in RUN.

`timescale 1ns/1ns

module micro_seq (
  input  logic                   clk,
  input  logic                   rst_i,
  input  micro_pkg::inst_t       inst_i,
  input  logic                   inst_valid_i,
  output logic                   inst_ready_o,
  output micro_pkg::micro_addr_t uaddr_o,
  output micro_pkg::inst_t       cur_inst_o,
  input  micro_pkg::issue_t      issue_i,
  output micro_pkg::issue_t      issue_o,
  output logic                   issue_valid_o,
  input  logic                   issue_ready_i
);

  micro_pkg::seq_state_e  state_q;                  // IDLE or RUN.
  micro_pkg::micro_addr_t uaddr_q;                  // Current micro-address.
  micro_pkg::inst_t       inst_q;                   // Instruction being issued.

  logic out_xfer;                                   // Output word taken.
  logic last_xfer;                                  // End word taken.
  logic accept;                                     // Input instruction taken.

  // Handshake terms.
  assign issue_valid_o = (state_q == micro_pkg::RUN);
  assign out_xfer      = issue_valid_o & issue_ready_i;
  assign last_xfer     = out_xfer & issue_i.end_seq;
  assign inst_ready_o  = (state_q == micro_pkg::IDLE) | last_xfer;
  assign accept        = inst_valid_i & inst_ready_o;

  // State and address.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= micro_pkg::IDLE;
      uaddr_q <= '0;
    end else if (accept) begin
      state_q <= micro_pkg::RUN;                    // Also covers reload at end.
      uaddr_q <= inst_i.start;
    end else if (last_xfer) begin
      state_q <= micro_pkg::IDLE;                   // Address holds at the end word.
    end else if (out_xfer) begin
      uaddr_q <= uaddr_q + micro_pkg::micro_addr_t'(1); // Next micro-word.
    end
  end

  // Operand fields for the whole sequence.
  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
    end
  end

  assign uaddr_o    = uaddr_q;
  assign cur_inst_o = inst_q;
  assign issue_o    = issue_i;                      // ROM and expander are combinational.

  // A stalled word must not advance the sequence.
  a_addr_hold: assert property (
    @(posedge clk) disable iff (rst_i)
    (state_q == micro_pkg::RUN && !issue_ready_i) |=> $stable(uaddr_q)
  ) else $error("micro_seq: micro-address moved during a stall");

  // Stall holds the whole ROM and expander path steady.
  a_out_stable: assert property (
    @(posedge clk) disable iff (rst_i)
    (issue_valid_o && !issue_ready_i) |=> (issue_valid_o && $stable(issue_o))
  ) else $error("micro_seq: issued word changed while stalled");

endmodule

//--- logic/micro_unit.sv
// Microcode issue stage top, streaming in and out with valid/ready.
// No internal pipeline beyond the sequencer registers.
// ROM_DEPTH must cover every address the table uses.

`timescale 1ns/1ns

module micro_unit #(
  parameter int ROM_DEPTH = 16                      // Passed to the ROM.
) (
  input  logic              clk,
  input  logic              rst_i,
  input  micro_pkg::inst_t  inst_i,
  input  logic              inst_valid_i,
  output logic              inst_ready_o,
  output micro_pkg::issue_t issue_o,
  output logic              issue_valid_o,
  input  logic              issue_ready_i
);

  micro_pkg::micro_addr_t uaddr;                    // Sequencer to ROM.
  micro_pkg::micro_word_t rom_word;                 // ROM to expander.
  micro_pkg::inst_t       cur_inst;                 // Held instruction.
  micro_pkg::issue_t      issue_raw;                // Expanded word.

  micro_seq seq_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .inst_i        (inst_i),
    .inst_valid_i  (inst_valid_i),
    .inst_ready_o  (inst_ready_o),
    .uaddr_o       (uaddr),
    .cur_inst_o    (cur_inst),
    .issue_i       (issue_raw),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i)
  );

  micro_rom #(
    .ROM_DEPTH (ROM_DEPTH)
  ) rom_i (
    .addr_i (uaddr),
    .word_o (rom_word)
  );

  micro_data data_i (
    .word_i  (rom_word),
    .inst_i  (cur_inst),
    .issue_o (issue_raw)
  );

endmodule

//--- verification/micro_unit_tb.sv
// Testbench for micro_unit. Expected words come from the shared microcode table.
// Sequences start at 0, 1, 4 and 8. ROM_DEPTH is 16.
// Stops at the first error. Back-pressure uses a 64-cycle ready pattern.

`timescale 1ns/1ns

module micro_unit_tb;

  // Table header is also included by the ROM.
  `undef MICRO_PROGRAM_SVH
  `include "micro_program.svh"

  logic              clk = 1'b0;
  logic              rst_i;
  micro_pkg::inst_t  inst_i;
  logic              inst_valid_i;
  logic              inst_ready_o;
  micro_pkg::issue_t issue_o;
  logic              issue_valid_o;
  logic              issue_ready_i = 1'b1;          // Full ready outside stall test.

  int                seed = 35025;
  micro_pkg::inst_t  stim [$];                      // All instructions in send order.
  micro_pkg::inst_t  sent_q [$];                    // In flight. Head is being issued.
  int                accept_cyc [$];
  int                end_cyc [$];
  string             cur_test = "reset";
  int                word_idx = 0;                  // Word within head sequence.
  int                seqs_done = 0;
  int                mon_cycle = 0;
  int                cycle_count = 0;
  int                timeout_limit = 1000;
  logic              stall_on = 1'b0;
  logic              ready_pat [64];
  int                pat_idx = 0;
  logic              stalled_q = 1'b0;
  micro_pkg::issue_t stalled_word;
  logic [7:0]        seen_imm = '0;                 // Selector coverage.
  logic [3:0]        seen_a = '0;
  logic [3:0]        seen_b = '0;
  logic [3:0]        seen_c = '0;
  logic [3:0]        seen_d = '0;
  logic [1:0]        seen_s = '0;
  logic [1:0]        seen_off = '0;

  micro_unit #(.ROM_DEPTH(16)) dut_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .inst_i        (inst_i),
    .inst_valid_i  (inst_valid_i),
    .inst_ready_o  (inst_ready_o),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i)
  );

  always #20 clk = ~clk;                            // 40 ns period.

  task automatic stop_with_error(input string reason);
    $display("ERROR %s", reason);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_value(input string test, input logic [68:0] expected,
                               input logic [68:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %h actual %h", test, expected, actual);
      $display("Testbench failed");
      $fatal(1, "run stopped at first mismatch");
    end
  endtask

  // Words up to and including the first end_seq word.
  function automatic int seq_length(input micro_pkg::micro_addr_t start);
    micro_pkg::micro_word_t w;
    for (int n = 1; n <= 128; n++) begin
      w = micro_program(micro_pkg::micro_addr_t'(start + n - 1));
      if (w.end_seq) return n;
    end
    return 128;
  endfunction

  // Expected issued word for word idx of an instruction, by table lookup per field.
  function automatic micro_pkg::issue_t expected_issue(input micro_pkg::inst_t ins,
                                                       input int idx);
    micro_pkg::micro_word_t w;
    micro_pkg::issue_t      e;
    micro_pkg::reg_sel_t    pick_a [4];
    micro_pkg::reg_sel_t    pick_b [4];
    micro_pkg::reg_sel_t    pick_c [4];
    micro_pkg::reg_sel_t    pick_d [4];
    micro_pkg::seg_sel_t    pick_s [2];
    micro_pkg::word_t       off_tab [2];
    micro_pkg::word_t       imm_tab [8];
    w = micro_program(micro_pkg::micro_addr_t'(ins.start + idx));
    pick_a = '{w.micro_a, ins.base, ins.dst, ins.src};
    pick_b = '{w.micro_b, ins.index, ins.src, ins.src};
    pick_c = '{w.micro_c, ins.dst, ins.src, ins.src};
    pick_d = '{w.micro_d, ins.dst, ins.src, ins.src};
    pick_s = '{w.micro_s, ins.seg};
    off_tab = '{16'h0000, ins.off};
    imm_tab = '{16'h0000, 16'h0002, 16'h0004, ins.off, ins.imm, 16'hffff, 16'h0003, 16'h0001};
    e.ir.high_ir = w.high_ir;
    e.ir.addr_a  = pick_a[w.var_a];
    e.ir.addr_b  = pick_b[w.var_b];
    e.ir.addr_c  = pick_c[w.var_c];
    e.ir.addr_d  = pick_d[w.var_d];
    e.ir.addr_s  = pick_s[w.var_s];
    e.off        = off_tab[w.var_off];              // Gated displacement.
    e.imm        = imm_tab[int'(w.var_imm)];
    e.end_seq    = w.end_seq;
    return e;
  endfunction

  function automatic micro_pkg::inst_t random_inst(input micro_pkg::micro_addr_t start);
    micro_pkg::inst_t ins;
    ins.start = start;
    ins.src   = micro_pkg::reg_sel_t'($random(seed));
    ins.dst   = micro_pkg::reg_sel_t'($random(seed));
    ins.base  = micro_pkg::reg_sel_t'($random(seed));
    ins.index = micro_pkg::reg_sel_t'($random(seed));
    ins.seg   = micro_pkg::seg_sel_t'($random(seed));
    ins.off   = micro_pkg::word_t'($random(seed));
    ins.imm   = micro_pkg::word_t'($random(seed));
    return ins;
  endfunction

  // Holds valid across a run of instructions, then waits for the last to drain.
  task automatic send_stream(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      inst_i       <= stim[i];
      inst_valid_i <= 1'b1;
      do @(posedge clk); while (!inst_ready_o);     // Accepted at this edge.
    end
    inst_valid_i <= 1'b0;
    wait (seqs_done == first + count);
    @(posedge clk);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      stop_with_error($sformatf("timeout after %0d cycles", cycle_count));
    end
  end

  // Ready pattern for the stall test.
  always @(posedge clk) begin
    if (stall_on) begin
      issue_ready_i <= (pat_idx < 64) ? ready_pat[pat_idx] : 1'b1;
      pat_idx = pat_idx + 1;
    end else begin
      issue_ready_i <= 1'b1;
    end
  end

  // Comparison process on pre-edge values.
  always @(posedge clk) begin
    micro_pkg::micro_word_t w;
    mon_cycle = mon_cycle + 1;
    if (!rst_i) begin
      if (stalled_q) begin
        if (!issue_valid_o) stop_with_error("issue valid dropped during a stall");
        compare_value("stall_hold", stalled_word, issue_o);
      end
      if (issue_valid_o && issue_ready_i) begin
        if (sent_q.size() == 0) begin
          stop_with_error("word issued with no instruction pending");
        end else if (word_idx >= seq_length(sent_q[0].start)) begin
          stop_with_error("sequence overran its table length");
        end
        compare_value(cur_test, expected_issue(sent_q[0], word_idx), issue_o);
        w = micro_program(micro_pkg::micro_addr_t'(sent_q[0].start + word_idx));
        seen_imm[int'(w.var_imm)] = 1'b1;
        seen_a[w.var_a]     = 1'b1;
        seen_b[w.var_b]     = 1'b1;
        seen_c[w.var_c]     = 1'b1;
        seen_d[w.var_d]     = 1'b1;
        seen_s[w.var_s]     = 1'b1;
        seen_off[w.var_off] = 1'b1;
        if (issue_o.end_seq) begin
          void'(sent_q.pop_front());                // Sequence complete.
          word_idx  = 0;
          seqs_done = seqs_done + 1;
          end_cyc.push_back(mon_cycle);
        end else begin
          word_idx = word_idx + 1;
        end
      end
      if (inst_valid_i && inst_ready_o) begin
        if (sent_q.size() != 0) stop_with_error("instruction accepted mid-sequence");
        sent_q.push_back(inst_i);
        accept_cyc.push_back(mon_cycle);
      end
      stalled_q    = issue_valid_o && !issue_ready_i;
      stalled_word = issue_o;
    end
  end

  initial begin
    micro_pkg::micro_addr_t starts [4];
    micro_pkg::inst_t       ins;
    int                     sum_len;
    int                     stall_cycles;
    int                     b2b_len;
    int                     i0;
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    starts       = '{7'd0, 7'd1, 7'd4, 7'd8};
    for (int i = 0; i < 4; i++) stim.push_back(random_inst(starts[i]));
    for (int i = 0; i < 4; i++) begin
      ins       = '{start: starts[i], src: 4'ha, dst: 4'hb, base: 4'hc, index: 4'hd,
                    seg: 2'd3, off: 16'h1357, imm: 16'h9bdf};
      stim.push_back(ins);                          // Distinct nonzero operands.
    end
    for (int i = 0; i < 20; i++) stim.push_back(random_inst(starts[$random(seed) & 3]));
    sum_len      = 0;
    stall_cycles = 0;
    foreach (stim[i]) sum_len += seq_length(stim[i].start);
    for (int i = 0; i < 64; i++) begin
      ready_pat[i] = (($random(seed) & 3) != 0);    // About one stall in four.
      if (!ready_pat[i]) stall_cycles++;
    end
    timeout_limit = 2 * sum_len + stall_cycles + 100;

    repeat (10) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);
    compare_value("reset_valid", 69'(1'b0), 69'(issue_valid_o));
    compare_value("reset_ready", 69'(1'b1), 69'(inst_ready_o));

    cur_test = "full_ready";
    for (int i = 0; i < 4; i++) send_stream(i, 1);
    cur_test = "substitution";
    for (int i = 4; i < 8; i++) send_stream(i, 1);

    cur_test = "back_pressure";
    stall_on <= 1'b1;
    send_stream(8, 12);
    stall_on <= 1'b0;

    cur_test = "back_to_back";
    i0      = accept_cyc.size();
    b2b_len = 0;
    for (int i = 20; i < 28; i++) b2b_len += seq_length(stim[i].start);
    send_stream(20, 8);
    compare_value("back_to_back_cycles", 69'(b2b_len),
                  69'(end_cyc[end_cyc.size() - 1] - accept_cyc[i0]));

    compare_value("drained", 69'(0), 69'(sent_q.size()));
    compare_value("imm_selectors", 69'(8'hff), 69'(seen_imm));
    compare_value("sel_a", 69'(4'hf), 69'(seen_a));
    compare_value("sel_b", 69'(4'hf), 69'(seen_b));
    compare_value("sel_c", 69'(4'hf), 69'(seen_c));
    compare_value("sel_d", 69'(4'hf), 69'(seen_d));
    compare_value("sel_s", 69'(2'b11), 69'(seen_s));
    compare_value("sel_off", 69'(2'b11), 69'(seen_off));
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
logic/micro_pkg.sv
logic/micro_rom.sv
logic/micro_data.sv
logic/micro_seq.sv
logic/micro_unit.sv
verification/micro_unit_tb.sv

//--- Makefile
# Verilator build and run for the microcode issue stage testbench.

SRCS := $(filter-out +incdir%,$(shell cat all.f)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vmicro_unit_tb: all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module micro_unit_tb \
		-o Vmicro_unit_tb

run: obj_dir/Vmicro_unit_tb
	./obj_dir/Vmicro_unit_tb | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
